/* common/rv_pkg.sv */
package rv_pkg;

   localparam int XLEN = 64;
   localparam int REG_AW = 5;          // register address bits
   localparam int DMEM_WORDS = 64;     // data ram depth in doublewords
   localparam int DMEM_AW = $clog2(DMEM_WORDS);

   // major opcodes
   localparam logic [6:0] OPC_LUI = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC = 7'b0010111;
   localparam logic [6:0] OPC_JAL = 7'b1101111;
   localparam logic [6:0] OPC_JALR = 7'b1100111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_LOAD = 7'b0000011;
   localparam logic [6:0] OPC_STORE = 7'b0100011;
   localparam logic [6:0] OPC_OPIMM = 7'b0010011;
   localparam logic [6:0] OPC_OP = 7'b0110011;
   localparam logic [6:0] OPC_OPIMM32 = 7'b0011011;
   localparam logic [6:0] OPC_OP32 = 7'b0111011;

   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_SLL = 3'b001;
   localparam logic [2:0] F3_SLT = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_SRL = 3'b101;   // srl and sra
   localparam logic [2:0] F3_OR = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;

   localparam logic [2:0] F3_BEQ = 3'b000;
   localparam logic [2:0] F3_BNE = 3'b001;
   localparam logic [2:0] F3_BLT = 3'b100;
   localparam logic [2:0] F3_BGE = 3'b101;
   localparam logic [2:0] F3_BLTU = 3'b110;
   localparam logic [2:0] F3_BGEU = 3'b111;

   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_ALT = 7'b0100000;   // sub, sra

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
      ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
   } alu_op_t;

   typedef enum logic [3:0] {
      BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
      BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
   } br_op_t;

   typedef enum logic {OPB_REG, OPB_IMM} opb_sel_t;
   typedef enum logic [1:0] {OPA_REG, OPA_PC, OPA_ZERO} opa_sel_t;
   typedef enum logic [1:0] {WB_ALU, WB_LSU, WB_PC4} wb_sel_t;
   typedef enum logic [1:0] {MEM_B, MEM_H, MEM_W, MEM_D} mem_size_t;

   typedef struct packed {
      logic [6:0] funct7;
      logic [REG_AW-1:0] rs2;
      logic [REG_AW-1:0] rs1;
      logic [2:0] funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [REG_AW-1:0] rs1;
      logic [2:0] funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0] opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_hi;
      logic [REG_AW-1:0] rs2;
      logic [REG_AW-1:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } s_fmt_t;

   typedef struct packed {
      logic imm_12;
      logic [5:0] imm_10_5;
      logic [REG_AW-1:0] rs2;
      logic [REG_AW-1:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic imm_11;
      logic [6:0] opcode;
   } b_fmt_t;

   typedef struct packed {
      logic [19:0] imm;
      logic [REG_AW-1:0] rd;
      logic [6:0] opcode;
   } u_fmt_t;

   typedef struct packed {
      logic imm_20;
      logic [9:0] imm_10_1;
      logic imm_11;
      logic [7:0] imm_19_12;
      logic [REG_AW-1:0] rd;
      logic [6:0] opcode;
   } j_fmt_t;

   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      s_fmt_t s;
      b_fmt_t b;
      u_fmt_t u;
      j_fmt_t j;
   } insn_t;

endpackage

/* exu/alu.sv */
`timescale 1ns/100ps

module alu import rv_pkg::*; (
   input logic [XLEN-1:0] i_op_a,
   input logic [XLEN-1:0] i_op_b,
   input logic [XLEN-1:0] i_rs1,
   input logic [XLEN-1:0] i_rs2,
   input logic [XLEN-1:0] i_pc,
   input alu_op_t i_alu_op,
   input logic i_word_op,
   input br_op_t i_br_op,
   input logic [XLEN-1:0] i_imm,
   output logic [XLEN-1:0] o_result,
   output logic [XLEN-1:0] o_next_pc,
   output logic o_br_taken
);

   logic [5:0] shamt;
   logic [XLEN-1:0] a_srl, a_sra;
   logic [XLEN-1:0] res;
   logic br_eq, br_lt, br_ltu;
   logic [XLEN-1:0] jalr_tgt;

   assign shamt = i_word_op ? {1'b0, i_op_b[4:0]} : i_op_b[5:0];

   // w-form right shifts work on the low word only
   assign a_srl = i_word_op ? {32'b0, i_op_a[31:0]} : i_op_a;
   assign a_sra = i_word_op ? {{32{i_op_a[31]}}, i_op_a[31:0]} : i_op_a;

   always_comb begin
      case (i_alu_op)
         ALU_ADD: res = i_op_a + i_op_b;
         ALU_SUB: res = i_op_a - i_op_b;
         ALU_SLL: res = i_op_a << shamt;
         ALU_SLT: res = {{(XLEN-1){1'b0}}, $signed(i_op_a) < $signed(i_op_b)};
         ALU_SLTU: res = {{(XLEN-1){1'b0}}, i_op_a < i_op_b};
         ALU_XOR: res = i_op_a ^ i_op_b;
         ALU_SRL: res = a_srl >> shamt;
         ALU_SRA: res = $unsigned($signed(a_sra) >>> shamt);
         ALU_OR: res = i_op_a | i_op_b;
         ALU_AND: res = i_op_a & i_op_b;
         default: res = '0;
      endcase
   end

   assign o_result = i_word_op ? {{32{res[31]}}, res[31:0]} : res;

   assign br_eq = (i_rs1 == i_rs2);
   assign br_lt = ($signed(i_rs1) < $signed(i_rs2));
   assign br_ltu = (i_rs1 < i_rs2);

   // jumps count as taken so retire shows every redirect
   always_comb begin
      case (i_br_op)
         BR_BEQ: o_br_taken = br_eq;
         BR_BNE: o_br_taken = !br_eq;
         BR_BLT: o_br_taken = br_lt;
         BR_BGE: o_br_taken = !br_lt;
         BR_BLTU: o_br_taken = br_ltu;
         BR_BGEU: o_br_taken = !br_ltu;
         BR_JAL, BR_JALR: o_br_taken = 1'b1;
         default: o_br_taken = 1'b0;
      endcase
   end

   assign jalr_tgt = i_rs1 + i_imm;

   always_comb begin
      if (i_br_op == BR_JALR)
         o_next_pc = {jalr_tgt[XLEN-1:1], 1'b0};
      else if (o_br_taken)
         o_next_pc = i_pc + i_imm;
      else
         o_next_pc = i_pc + 64'd4;
   end

endmodule

/* idu/idu.sv */
`timescale 1ns/100ps

module idu import rv_pkg::*; (
   input insn_t i_insn,
   input logic i_valid,
   output logic o_valid,
   output logic o_illegal,
   output logic o_rf_we,
   output logic [REG_AW-1:0] o_rd,
   output logic [REG_AW-1:0] o_rs1_addr,
   output logic [REG_AW-1:0] o_rs2_addr,
   output opa_sel_t o_opa_sel,
   output opb_sel_t o_opb_sel,
   output alu_op_t o_alu_op,
   output logic o_word_op,
   output br_op_t o_br_op,
   output logic o_load,
   output logic o_store,
   output mem_size_t o_mem_size,
   output logic o_mem_unsigned,
   output wb_sel_t o_wb_sel,
   output logic [XLEN-1:0] o_imm
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic f7_base, f7_alt;
   logic f6_base, f6_alt;
   alu_op_t f3_op;
   logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

   assign opcode = i_insn.r.opcode;
   assign funct3 = i_insn.r.funct3;
   assign funct7 = i_insn.r.funct7;

   assign f7_base = (funct7 == F7_BASE);
   assign f7_alt = (funct7 == F7_ALT);
   assign f6_base = (funct7[6:1] == F7_BASE[6:1]); // rv64 shifts use a 6-bit shamt
   assign f6_alt = (funct7[6:1] == F7_ALT[6:1]);

   assign imm_i = {{(XLEN-12){i_insn.i.imm[11]}}, i_insn.i.imm};
   assign imm_s = {{(XLEN-12){i_insn.s.imm_hi[6]}}, i_insn.s.imm_hi, i_insn.s.imm_lo};
   assign imm_b = {{(XLEN-12){i_insn.b.imm_12}}, i_insn.b.imm_11, i_insn.b.imm_10_5,
                   i_insn.b.imm_4_1, 1'b0};
   assign imm_u = {{(XLEN-32){i_insn.u.imm[19]}}, i_insn.u.imm, 12'b0};
   assign imm_j = {{(XLEN-20){i_insn.j.imm_20}}, i_insn.j.imm_19_12, i_insn.j.imm_11,
                   i_insn.j.imm_10_1, 1'b0};

   // funct3 maps to the alu op and bit 30 picks the arithmetic shift
   always_comb begin
      case (funct3)
         F3_ADD: f3_op = ALU_ADD;
         F3_SLL: f3_op = ALU_SLL;
         F3_SLT: f3_op = ALU_SLT;
         F3_SLTU: f3_op = ALU_SLTU;
         F3_XOR: f3_op = ALU_XOR;
         F3_SRL: f3_op = funct7[5] ? ALU_SRA : ALU_SRL;
         F3_OR: f3_op = ALU_OR;
         default: f3_op = ALU_AND;
      endcase
   end

   always_comb begin
      o_illegal = 1'b0;
      o_rf_we = 1'b1;
      o_opa_sel = OPA_REG;
      o_opb_sel = OPB_IMM;
      o_alu_op = ALU_ADD;   // also the address adder for loads and stores
      o_word_op = 1'b0;
      o_br_op = BR_NONE;
      o_load = 1'b0;
      o_store = 1'b0;
      o_mem_size = mem_size_t'(funct3[1:0]);
      o_mem_unsigned = funct3[2];
      o_wb_sel = WB_ALU;
      o_imm = imm_i;

      case (opcode)
         OPC_LUI: begin
            o_opa_sel = OPA_ZERO;
            o_imm = imm_u;
         end
         OPC_AUIPC: begin
            o_opa_sel = OPA_PC;
            o_imm = imm_u;
         end
         OPC_JAL: begin
            o_br_op = BR_JAL;
            o_wb_sel = WB_PC4;  // link value
            o_imm = imm_j;
         end
         OPC_JALR: begin
            o_br_op = BR_JALR;
            o_wb_sel = WB_PC4;
            o_illegal = (funct3 != 3'b000);
         end
         OPC_BRANCH: begin
            o_rf_we = 1'b0;
            o_opb_sel = OPB_REG;
            o_imm = imm_b;
            case (funct3)
               F3_BEQ: o_br_op = BR_BEQ;
               F3_BNE: o_br_op = BR_BNE;
               F3_BLT: o_br_op = BR_BLT;
               F3_BGE: o_br_op = BR_BGE;
               F3_BLTU: o_br_op = BR_BLTU;
               F3_BGEU: o_br_op = BR_BGEU;
               default: o_illegal = 1'b1;
            endcase
         end
         OPC_LOAD: begin
            o_load = 1'b1;
            o_wb_sel = WB_LSU;
            o_illegal = (funct3 == 3'b111); // no unsigned doubleword
         end
         OPC_STORE: begin
            o_rf_we = 1'b0;
            o_store = 1'b1;
            o_imm = imm_s;
            o_illegal = funct3[2];
         end
         OPC_OPIMM: begin
            o_alu_op = f3_op;
            if (funct3 == F3_SLL)
               o_illegal = !f6_base;
            else if (funct3 == F3_SRL)
               o_illegal = !(f6_base || f6_alt);
         end
         OPC_OPIMM32: begin
            o_alu_op = f3_op;
            o_word_op = 1'b1;
            case (funct3)
               F3_ADD: o_illegal = 1'b0;
               F3_SLL: o_illegal = !f7_base;
               F3_SRL: o_illegal = !(f7_base || f7_alt);
               default: o_illegal = 1'b1;
            endcase
         end
         OPC_OP, OPC_OP32: begin
            o_opb_sel = OPB_REG;
            o_word_op = (opcode == OPC_OP32);
            o_alu_op = (funct3 == F3_ADD && f7_alt) ? ALU_SUB : f3_op;
            if (f7_alt)
               o_illegal = !(funct3 == F3_ADD || funct3 == F3_SRL);
            else if (!f7_base)
               o_illegal = 1'b1;
            else if (o_word_op) // only add, sll and srl have a w form
               o_illegal = !(funct3 == F3_ADD || funct3 == F3_SLL || funct3 == F3_SRL);
         end
         default: o_illegal = 1'b1;
      endcase

      if (o_illegal) begin
         o_rf_we = 1'b0;
         o_load = 1'b0;
         o_store = 1'b0;
         o_br_op = BR_NONE;
      end
   end

   assign o_rd = i_insn.r.rd;
   assign o_rs1_addr = i_insn.r.rs1;
   assign o_rs2_addr = i_insn.r.rs2;
   assign o_valid = i_valid;

endmodule

/* lsu/lsu.sv */
`timescale 1ns/100ps

module lsu import rv_pkg::*; (
   input logic i_clk,
   input logic i_load,
   input logic i_store,
   input mem_size_t i_size,
   input logic i_unsigned,
   input logic [XLEN-1:0] i_addr,
   input logic [XLEN-1:0] i_wdata,
   output logic [XLEN-1:0] o_rdata
);

   logic [XLEN-1:0] mem [DMEM_WORDS];

   logic [DMEM_AW-1:0] idx;
   logic [2:0] lane;
   logic [7:0] be_base;
   logic [15:0] be_rot;
   logic [7:0] be;
   logic [2*XLEN-1:0] wd_rot;
   logic [2*XLEN-1:0] rd_rot;
   logic [XLEN-1:0] raw;

   assign idx = i_addr[3 +: DMEM_AW];  // upper address bits ignored
   assign lane = i_addr[2:0];

   always_comb begin
      case (i_size)
         MEM_B: be_base = 8'h01;
         MEM_H: be_base = 8'h03;
         MEM_W: be_base = 8'h0f;
         default: be_base = 8'hff;
      endcase
   end

   // rotate lanes so a misaligned access wraps inside the doubleword
   assign be_rot = {be_base, be_base} << lane;
   assign be = be_rot[15:8];
   assign wd_rot = {i_wdata, i_wdata} << {lane, 3'b000};

   always_ff @(posedge i_clk) begin
      if (i_store) begin
         for (int b = 0; b < 8; b++) begin
            if (be[b])
               mem[idx][b*8 +: 8] <= wd_rot[XLEN + b*8 +: 8];
         end
      end
   end

   assign rd_rot = {mem[idx], mem[idx]} >> {lane, 3'b000};
   assign raw = rd_rot[XLEN-1:0];

   always_comb begin
      if (!i_load)
         o_rdata = '0;
      else begin
         case (i_size)
            MEM_B: o_rdata = {{(XLEN-8){!i_unsigned & raw[7]}}, raw[7:0]};
            MEM_H: o_rdata = {{(XLEN-16){!i_unsigned & raw[15]}}, raw[15:0]};
            MEM_W: o_rdata = {{(XLEN-32){!i_unsigned & raw[31]}}, raw[31:0]};
            default: o_rdata = raw;
         endcase
      end
   end

endmodule

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_core -f vlog.f -o tb_core

./obj_dir/tb_core > sim.log
cat sim.log

if grep -q "Test FAILED" sim.log; then
   echo "simulation reported a failure, see sim.log"
   exit 1
fi

echo "simulation finished without failure"

/* sim/tb_core.sv */
`timescale 1ns/100ps

module tb_core import rv_pkg::*; ();

   localparam int N_RAND = 500;
   localparam int N_PRE = 2 * 31 + DMEM_WORDS;  // lui and addi per register plus one sd per doubleword
   localparam int RESET_CYCLES = 2;
   localparam int LEAD_IDLE = 3;
   localparam int TAIL_IDLE = 4;
   // each random instruction may be followed by one bubble
   localparam int CYCLE_LIMIT = RESET_CYCLES + LEAD_IDLE + N_PRE + 2 * N_RAND + TAIL_IDLE + 20;

   typedef struct packed {
      logic illegal;
      logic we;
      logic [REG_AW-1:0] rd;
      logic [XLEN-1:0] data;
      logic [XLEN-1:0] next_pc;
      logic br_taken;
      logic [XLEN-1:0] pc;
      logic [31:0] cycle;   // cycle count when issued
   } exp_t;

   logic clk, reset, valid;
   insn_t insn;
   logic [XLEN-1:0] pc;
   logic ret_valid, ret_illegal, ret_we, ret_br_taken;
   logic [REG_AW-1:0] ret_rd;
   logic [XLEN-1:0] ret_data, ret_next_pc;

   logic [15:0] lfsr;
   logic [XLEN-1:0] rf_model [32];
   logic [XLEN-1:0] mem_model [DMEM_WORDS];
   exp_t exp_q [$];
   int unsigned cycle, errors, checked;

   core_top i_dut (
      .i_clk(clk), .i_reset(reset), .i_valid(valid), .i_insn(insn), .i_pc(pc),
      .o_retire_valid(ret_valid), .o_retire_illegal(ret_illegal), .o_retire_we(ret_we),
      .o_retire_rd(ret_rd), .o_retire_data(ret_data), .o_retire_next_pc(ret_next_pc),
      .o_retire_br_taken(ret_br_taken)
   );

   always #2 clk = ~clk;

   always @(posedge clk) cycle <= cycle + 1;

   // taps x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic fb;
      v = '0;
      for (int k = 0; k < n; k++) begin
         fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         v = {v[30:0], lfsr[15]};
         lfsr = {lfsr[14:0], fb};
      end
      return v;
   endfunction

   function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                               input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b, input logic word);
      logic [31:0] r32;
      logic [XLEN-1:0] r;
      if (word) begin
         case (f3)
            F3_SLL: r32 = a[31:0] << b[4:0];
            F3_SRL: r32 = alt ? $unsigned($signed(a[31:0]) >>> b[4:0]) : a[31:0] >> b[4:0];
            default: r32 = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
         endcase
         return {{32{r32[31]}}, r32};
      end
      case (f3)
         F3_ADD: r = alt ? a - b : a + b;
         F3_SLL: r = a << b[5:0];
         F3_SLT: r = {63'd0, $signed(a) < $signed(b)};
         F3_SLTU: r = {63'd0, a < b};
         F3_XOR: r = a ^ b;
         F3_SRL: r = alt ? $unsigned($signed(a) >>> b[5:0]) : a >> b[5:0];
         F3_OR: r = a | b;
         default: r = a & b;
      endcase
      return r;
   endfunction

   // executes one instruction on the model state and returns its retire record
   function automatic exp_t ref_exec(input logic [31:0] w, input logic [XLEN-1:0] at_pc);
      exp_t e;
      logic [6:0] opc, f7;
      logic [2:0] f3;
      logic [4:0] rd;
      logic [XLEN-1:0] a, b, imm_i, imm_s, imm_b, imm_u, imm_j, addr, raw;
      logic [DMEM_AW-1:0] idx;
      logic [2:0] lane;
      logic taken;
      int nb;
      opc = w[6:0];
      rd = w[11:7];
      f3 = w[14:12];
      f7 = w[31:25];
      a = rf_model[w[19:15]];
      b = rf_model[w[24:20]];
      imm_i = {{52{w[31]}}, w[31:20]};
      imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
      imm_b = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      imm_u = {{32{w[31]}}, w[31:12], 12'h000};
      imm_j = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      e = '0;
      e.pc = at_pc;
      e.rd = rd;
      e.we = 1'b1;
      e.next_pc = at_pc + 64'd4;
      taken = 1'b0;
      case (opc)
         OPC_LUI: e.data = imm_u;
         OPC_AUIPC: e.data = at_pc + imm_u;
         OPC_JAL: begin
            e.data = at_pc + 64'd4;
            e.next_pc = at_pc + imm_j;
            e.br_taken = 1'b1;
         end
         OPC_JALR: begin
            e.data = at_pc + 64'd4;
            e.next_pc = (a + imm_i) & ~64'd1;
            e.br_taken = 1'b1;
            e.illegal = (f3 != 3'd0);
         end
         OPC_BRANCH: begin
            e.we = 1'b0;
            case (f3)
               F3_BEQ: taken = (a == b);
               F3_BNE: taken = (a != b);
               F3_BLT: taken = ($signed(a) < $signed(b));
               F3_BGE: taken = ($signed(a) >= $signed(b));
               F3_BLTU: taken = (a < b);
               F3_BGEU: taken = (a >= b);
               default: e.illegal = 1'b1;
            endcase
            e.br_taken = taken;
            if (taken) e.next_pc = at_pc + imm_b;
         end
         OPC_LOAD: begin
            addr = a + imm_i;
            idx = addr[3 +: DMEM_AW];
            lane = addr[2:0];
            raw = mem_model[idx] >> {lane, 3'b000};
            case (f3)
               3'd0: e.data = {{56{raw[7]}}, raw[7:0]};
               3'd1: e.data = {{48{raw[15]}}, raw[15:0]};
               3'd2: e.data = {{32{raw[31]}}, raw[31:0]};
               3'd3: e.data = raw;
               3'd4: e.data = {56'd0, raw[7:0]};
               3'd5: e.data = {48'd0, raw[15:0]};
               3'd6: e.data = {32'd0, raw[31:0]};
               default: e.illegal = 1'b1;
            endcase
         end
         OPC_STORE: begin
            e.we = 1'b0;
            e.illegal = f3[2];
            addr = a + imm_s;
            idx = addr[3 +: DMEM_AW];
            lane = addr[2:0];
            nb = 1 << f3[1:0];
            if (!e.illegal) begin
               for (int k = 0; k < nb; k++)
                  mem_model[idx][(lane + k) * 8 +: 8] = b[k * 8 +: 8];
            end
         end
         OPC_OPIMM: begin
            e.illegal = (f3 == F3_SLL && w[31:26] != 6'd0) ||
                        (f3 == F3_SRL && w[31:26] != 6'd0 && w[31:26] != 6'b010000);
            e.data = alu_ref(f3, (f3 == F3_SRL) && w[30], a, imm_i, 1'b0);
         end
         OPC_OP: begin
            e.illegal = !(f7 == F7_BASE || (f7 == F7_ALT && (f3 == F3_ADD || f3 == F3_SRL)));
            e.data = alu_ref(f3, w[30], a, b, 1'b0);
         end
         OPC_OPIMM32: begin
            e.illegal = !(f3 == F3_ADD || (f3 == F3_SLL && f7 == F7_BASE) ||
                          (f3 == F3_SRL && (f7 == F7_BASE || f7 == F7_ALT)));
            e.data = alu_ref(f3, (f3 == F3_SRL) && w[30], a, imm_i, 1'b1);
         end
         OPC_OP32: begin
            e.illegal = !(((f3 == F3_ADD || f3 == F3_SRL) && (f7 == F7_BASE || f7 == F7_ALT)) ||
                          (f3 == F3_SLL && f7 == F7_BASE));
            e.data = alu_ref(f3, w[30], a, b, 1'b1);
         end
         default: e.illegal = 1'b1;
      endcase
      if (e.illegal) begin
         e.we = 1'b0;
         e.br_taken = 1'b0;
      end else if (e.we && rd != 5'd0) begin
         rf_model[rd] = e.data;
      end
      return e;
   endfunction

   // loads and stores use x0 as base so every address is aligned and in range
   function automatic logic [31:0] gen_insn();
      insn_t w;
      logic [3:0] cls;
      logic [2:0] f3, ln;
      logic [1:0] t2;
      logic [11:0] imm;
      logic [DMEM_AW-1:0] dw;
      w = '0;
      cls = 4'(rand_bits(4));
      w.r.rd = 5'(rand_bits(4));   // x0..x15 keeps dependencies frequent
      w.r.rs1 = 5'(rand_bits(4));
      w.r.rs2 = 5'(rand_bits(4));
      t2 = 2'(rand_bits(2));
      case (cls)
         4'd0, 4'd1: begin
            w.u.opcode = (cls == 4'd0) ? OPC_LUI : OPC_AUIPC;
            w.u.imm = 20'(rand_bits(20));
         end
         4'd2: begin
            w.j.opcode = OPC_JAL;
            {w.j.imm_20, w.j.imm_19_12, w.j.imm_11, w.j.imm_10_1} = 20'(rand_bits(20));
         end
         4'd3: begin
            w.i.opcode = OPC_JALR;
            w.i.imm = 12'(rand_bits(12));
         end
         4'd4, 4'd5: begin
            f3 = 3'(rand_bits(3));
            if (f3[2:1] == 2'b01) f3[2] = 1'b1;
            w.b.opcode = OPC_BRANCH;
            w.b.funct3 = f3;
            {w.b.imm_12, w.b.imm_11, w.b.imm_10_5, w.b.imm_4_1} = 12'(rand_bits(12));
         end
         4'd6, 4'd7, 4'd8, 4'd9: begin
            f3 = (cls < 4'd8) ? 3'(rand_bits(3)) : {1'b0, 2'(rand_bits(2))};
            if (f3 == 3'd7) f3 = 3'd3;
            dw = DMEM_AW'(rand_bits(DMEM_AW));
            ln = 3'(rand_bits(3));
            ln = ln >> f3[1:0] << f3[1:0];   // natural alignment
            imm = 12'({dw, ln});
            w.r.rs1 = 5'd0;
            if (cls < 4'd8) begin
               w.i.opcode = OPC_LOAD;
               w.i.funct3 = f3;
               w.i.imm = imm;
            end else begin
               w.s.opcode = OPC_STORE;
               w.s.funct3 = f3;
               w.s.imm_hi = imm[11:5];
               w.s.imm_lo = imm[4:0];
            end
         end
         4'd10, 4'd11: begin
            f3 = 3'(rand_bits(3));
            imm = 12'(rand_bits(12));
            if (f3 == F3_SLL) imm[11:6] = 6'd0;
            else if (f3 == F3_SRL) imm[11:6] = {1'b0, imm[10], 4'd0};
            w.i.opcode = OPC_OPIMM;
            w.i.funct3 = f3;
            w.i.imm = imm;
         end
         4'd12: begin
            f3 = 3'(rand_bits(3));
            w.r.opcode = OPC_OP;
            w.r.funct3 = f3;
            w.r.funct7 = ((f3 == F3_ADD || f3 == F3_SRL) && rand_bits(1) == 32'd1) ?
                         F7_ALT : F7_BASE;
         end
         4'd13, 4'd14: begin
            f3 = (t2 == 2'd1) ? F3_SLL : (t2 == 2'd2) ? F3_SRL : F3_ADD;
            if (cls == 4'd13) begin
               imm = 12'(rand_bits(12));
               if (f3 != F3_ADD) imm[11:5] = {1'b0, imm[10] & f3[2], 5'd0};
               w.i.opcode = OPC_OPIMM32;
               w.i.funct3 = f3;
               w.i.imm = imm;
            end else begin
               w.r.opcode = OPC_OP32;
               w.r.funct3 = f3;
               w.r.funct7 = (f3 != F3_SLL && rand_bits(1) == 32'd1) ? F7_ALT : F7_BASE;
            end
         end
         default: begin
            w = rand_bits(32);   // fence, system, amo, or an m-extension op
            case (t2)
               2'd0: w.r.opcode = 7'b0001111;
               2'd1: w.r.opcode = 7'b1110011;
               2'd2: w.r.opcode = 7'b0101111;
               default: begin
                  w.r.opcode = OPC_OP;
                  w.r.funct7 = 7'b0000001;
               end
            endcase
         end
      endcase
      return w;
   endfunction

   task automatic issue(input logic [31:0] w);
      exp_t e;
      valid = 1'b1;
      insn = w;
      e = ref_exec(w, pc);
      e.cycle = cycle;
      exp_q.push_back(e);
      @(negedge clk);
      pc = pc + 64'd4;   // no fetch, so the stream is sequential
   endtask

   task automatic idle();
      valid = 1'b0;
      @(negedge clk);
   endtask

   task automatic value_error(input string name, input logic [XLEN-1:0] at_pc,
                              input logic [XLEN-1:0] exp, input logic [XLEN-1:0] got);
      errors++;
      $display("error %s at pc %h: expected %h, got %h", name, at_pc, exp, got);
   endtask

   initial begin
      insn_t w;
      logic [11:0] off;
      clk = 1'b0;
      reset = 1'b1;
      valid = 1'b1;   // valid already high while reset is applied
      insn = '0;
      pc = 64'h1000;
      lfsr = 16'd48;
      errors = 0;
      checked = 0;
      rf_model[0] = '0;
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;
      repeat (LEAD_IDLE) idle();

      for (int r = 1; r < 32; r++) begin
         w = '0;
         w.u.opcode = OPC_LUI;
         w.u.rd = 5'(r);
         w.u.imm = 20'(rand_bits(20));
         issue(w);
         w = '0;
         w.i.opcode = OPC_OPIMM;
         w.i.rd = 5'(r);
         w.i.rs1 = 5'(r);
         w.i.imm = 12'(rand_bits(12));
         issue(w);
      end
      for (int d = 0; d < DMEM_WORDS; d++) begin
         off = 12'(d * 8);
         w = '0;
         w.s.opcode = OPC_STORE;
         w.s.funct3 = 3'd3;
         w.s.rs2 = 5'(1 + d % 31);
         w.s.imm_hi = off[11:5];
         w.s.imm_lo = off[4:0];
         issue(w);
      end

      for (int n = 0; n < N_RAND; n++) begin
         issue(gen_insn());
         if (rand_bits(2) == 32'd0) idle();
      end
      valid = 1'b0;

      while (exp_q.size() != 0) @(negedge clk);
      repeat (TAIL_IDLE) @(negedge clk);   // any late retire shows up as a stray one
      $display("%0d errors in %0d checked instructions", errors, checked);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

   always @(posedge clk) begin
      exp_t e;
      if (!reset && ret_valid) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("retire seen at cycle %0d with no instruction in flight", cycle);
         end else begin
            e = exp_q.pop_front();
            checked++;
            if (cycle != e.cycle + 32'd2) begin
               errors++;
               $display("pc %h retired at cycle %0d instead of %0d", e.pc, cycle, e.cycle + 2);
            end
            if (ret_illegal !== e.illegal)
               value_error("o_retire_illegal", e.pc, 64'(e.illegal), 64'(ret_illegal));
            if (ret_we !== e.we)
               value_error("o_retire_we", e.pc, 64'(e.we), 64'(ret_we));
            if (e.we && ret_rd !== e.rd)
               value_error("o_retire_rd", e.pc, 64'(e.rd), 64'(ret_rd));
            if (e.we && ret_data !== e.data)
               value_error("o_retire_data", e.pc, e.data, ret_data);
            if (!e.illegal && ret_next_pc !== e.next_pc)
               value_error("o_retire_next_pc", e.pc, e.next_pc, ret_next_pc);
            if (ret_br_taken !== e.br_taken)
               value_error("o_retire_br_taken", e.pc, 64'(e.br_taken), 64'(ret_br_taken));
         end
      end
   end

   always @(posedge clk) begin
      if (cycle >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles with %0d instructions still in flight",
                  CYCLE_LIMIT, exp_q.size());
         $display("%0d errors in %0d checked instructions", errors, checked);
         $display("Test FAILED");
         $finish;
      end
   end

endmodule

/* source/core_top.sv */
`timescale 1ns/100ps

module core_top import rv_pkg::*; (
   input logic i_clk,
   input logic i_reset,
   input logic i_valid,
   input insn_t i_insn,
   input logic [XLEN-1:0] i_pc,
   output logic o_retire_valid,
   output logic o_retire_illegal,
   output logic o_retire_we,
   output logic [REG_AW-1:0] o_retire_rd,
   output logic [XLEN-1:0] o_retire_data,
   output logic [XLEN-1:0] o_retire_next_pc,
   output logic o_retire_br_taken
);

   // decode outputs
   logic d_valid, d_illegal, d_rf_we, d_word_op, d_load, d_store, d_mem_unsigned;
   logic [REG_AW-1:0] d_rd, d_rs1, d_rs2;
   opa_sel_t d_opa_sel;
   opb_sel_t d_opb_sel;
   alu_op_t d_alu_op;
   br_op_t d_br_op;
   mem_size_t d_mem_size;
   wb_sel_t d_wb_sel;
   logic [XLEN-1:0] d_imm;

   // execute register
   logic ex_valid, ex_illegal, ex_rf_we, ex_word_op, ex_load, ex_store, ex_mem_unsigned;
   logic [REG_AW-1:0] ex_rd, ex_rs1, ex_rs2;
   opa_sel_t ex_opa_sel;
   opb_sel_t ex_opb_sel;
   alu_op_t ex_alu_op;
   br_op_t ex_br_op;
   mem_size_t ex_mem_size;
   wb_sel_t ex_wb_sel;
   logic [XLEN-1:0] ex_imm, ex_pc;

   logic [XLEN-1:0] rs1_data, rs2_data, op_a, op_b;
   logic [XLEN-1:0] alu_result, next_pc, load_data, wb_data;
   logic br_taken, rf_we;

   idu u_idu (
      .i_insn(i_insn), .i_valid(i_valid),
      .o_valid(d_valid), .o_illegal(d_illegal), .o_rf_we(d_rf_we), .o_rd(d_rd),
      .o_rs1_addr(d_rs1), .o_rs2_addr(d_rs2),
      .o_opa_sel(d_opa_sel), .o_opb_sel(d_opb_sel), .o_alu_op(d_alu_op),
      .o_word_op(d_word_op), .o_br_op(d_br_op), .o_load(d_load), .o_store(d_store),
      .o_mem_size(d_mem_size), .o_mem_unsigned(d_mem_unsigned),
      .o_wb_sel(d_wb_sel), .o_imm(d_imm)
   );

   always_ff @(posedge i_clk) begin
      if (i_reset)
         ex_valid <= 1'b0;
      else
         ex_valid <= d_valid;
   end

   always_ff @(posedge i_clk) begin
      ex_illegal <= d_illegal;
      ex_rf_we <= d_rf_we;
      ex_rd <= d_rd;
      ex_rs1 <= d_rs1;
      ex_rs2 <= d_rs2;
      ex_opa_sel <= d_opa_sel;
      ex_opb_sel <= d_opb_sel;
      ex_alu_op <= d_alu_op;
      ex_word_op <= d_word_op;
      ex_br_op <= d_br_op;
      ex_load <= d_load;
      ex_store <= d_store;
      ex_mem_size <= d_mem_size;
      ex_mem_unsigned <= d_mem_unsigned;
      ex_wb_sel <= d_wb_sel;
      ex_imm <= d_imm;
      ex_pc <= i_pc;
   end

   // written at the end of execute, so the next instruction sees it without forwarding
   assign rf_we = ex_valid & ex_rf_we;

   regfile u_regfile (
      .i_clk(i_clk), .i_we(rf_we), .i_waddr(ex_rd), .i_wdata(wb_data),
      .i_raddr1(ex_rs1), .i_raddr2(ex_rs2),
      .o_rdata1(rs1_data), .o_rdata2(rs2_data)
   );

   always_comb begin
      case (ex_opa_sel)
         OPA_REG: op_a = rs1_data;
         OPA_PC: op_a = ex_pc;
         default: op_a = '0;  // lui
      endcase
   end

   assign op_b = (ex_opb_sel == OPB_IMM) ? ex_imm : rs2_data;

   alu u_alu (
      .i_op_a(op_a), .i_op_b(op_b), .i_rs1(rs1_data), .i_rs2(rs2_data), .i_pc(ex_pc),
      .i_alu_op(ex_alu_op), .i_word_op(ex_word_op), .i_br_op(ex_br_op), .i_imm(ex_imm),
      .o_result(alu_result), .o_next_pc(next_pc), .o_br_taken(br_taken)
   );

   lsu u_lsu (
      .i_clk(i_clk), .i_load(ex_valid & ex_load), .i_store(ex_valid & ex_store),
      .i_size(ex_mem_size), .i_unsigned(ex_mem_unsigned),
      .i_addr(alu_result), .i_wdata(rs2_data), .o_rdata(load_data)
   );

   always_comb begin
      case (ex_wb_sel)
         WB_LSU: wb_data = load_data;
         WB_PC4: wb_data = ex_pc + 64'd4;
         default: wb_data = alu_result;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_reset)
         o_retire_valid <= 1'b0;
      else
         o_retire_valid <= ex_valid;
   end

   always_ff @(posedge i_clk) begin
      o_retire_illegal <= ex_illegal;
      o_retire_we <= rf_we;
      o_retire_rd <= ex_rd;
      o_retire_data <= wb_data;
      o_retire_next_pc <= next_pc;
      o_retire_br_taken <= br_taken;
   end

endmodule

/* source/regfile.sv */
`timescale 1ns/100ps

module regfile import rv_pkg::*; (
   input logic i_clk,
   input logic i_we,
   input logic [REG_AW-1:0] i_waddr,
   input logic [XLEN-1:0] i_wdata,
   input logic [REG_AW-1:0] i_raddr1,
   input logic [REG_AW-1:0] i_raddr2,
   output logic [XLEN-1:0] o_rdata1,
   output logic [XLEN-1:0] o_rdata2
);

   logic [XLEN-1:0] regs [2**REG_AW];

   always_ff @(posedge i_clk) begin
      if (i_we && i_waddr != '0)  // x0 stays zero
         regs[i_waddr] <= i_wdata;
   end

   assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
   assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

/* vlog.f */
common/rv_pkg.sv
idu/idu.sv
exu/alu.sv
lsu/lsu.sv
source/regfile.sv
source/core_top.sv
sim/tb_core.sv
